// File: Bender.yml
package:
  name: chien_search

sources:
  # design
  - design/chien_pkg.sv
  - design/chien_scan_ctrl.sv
  - design/chien_cell.sv
  - design/err_addr_collector.sv
  - design/chien_top.sv

  # testbench
  - target: test
    include_dirs:
      - tb
    files:
      - tb/chien_tb.sv

// File: design/chien_cell.sv
`timescale 1ns/1ps

module chien_cell #(
   parameter int PAR  = chien_pkg::PAR_DEFAULT,
   parameter int LANE = 0
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               load_i,
   input  logic               step_i,
   input  chien_pkg::lambda_t lambda_i,
   output logic               root_o
);
   import chien_pkg::*;

   logic [T_MAX:0][GF_M-1:0] coef;
   gf_elem_t                 term [T_MAX+1];
   gf_elem_t                 sum;

   assign coef = lambda_i;

   // --------------------------------------------------
   // term k holds coef_k * alpha^(-k*position)
   // --------------------------------------------------
   for (genvar k = 0; k <= T_MAX; k++)
   begin : g_term
      localparam gf_elem_t LOAD_C = gf_pow_alpha(-k * LANE);
      localparam gf_elem_t STEP_C = gf_pow_alpha(-k * PAR);   // jump one group

      gf_elem_t term_q;

      always_ff @(posedge clk or negedge rstn)
      begin
         if (!rstn)
            term_q <= '0;
         else if (load_i)
            term_q <= gf_mul(coef[k], LOAD_C);
         else if (step_i)
            term_q <= gf_mul(term_q, STEP_C);
      end

      assign term[k] = term_q;
   end

   always_comb
   begin
      sum = '0;
      for (int k = 0; k <= T_MAX; k++)
         sum = sum ^ term[k];
   end

   assign root_o = (sum == '0);                       // lambda(alpha^-pos) == 0

endmodule

// File: design/chien_pkg.sv
package chien_pkg;

   localparam int GF_M        = 13;
   localparam int GF_ORDER    = (1 << GF_M) - 1;    // 8191 nonzero elements
   localparam int T_MAX       = 8;
   localparam int CODE_LEN    = 4224;
   localparam int PAR_DEFAULT = 16;
   localparam int ADDR_W      = 13;

   localparam logic [GF_M:0] GF_POLY = 14'h201b;   // x^13 + x^4 + x^3 + x + 1

   typedef logic [GF_M-1:0] gf_elem_t;

   // --------------------------------------------------
   // field arithmetic
   // --------------------------------------------------
   function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
      gf_elem_t acc;
      gf_elem_t sh;
      acc = '0;
      sh  = a;                                         // a * x^i
      for (int i = 0; i < GF_M; i++)
      begin
         if (b[i])
            acc = acc ^ sh;
         sh = sh[GF_M-1] ? ((sh << 1) ^ GF_POLY[GF_M-1:0]) : (sh << 1);
      end
      return acc;
   endfunction

   // alpha^e, e may be negative
   function automatic gf_elem_t gf_pow_alpha(int e);
      int       r;
      gf_elem_t base;
      gf_elem_t acc;
      r = e % GF_ORDER;
      if (r < 0)
         r = r + GF_ORDER;
      base = gf_elem_t'(2);                            // alpha
      acc  = gf_elem_t'(1);
      for (int i = 0; i < GF_M; i++)
      begin
         if (r[i])
            acc = gf_mul(acc, base);
         base = gf_mul(base, base);                    // square and multiply
      end
      return acc;
   endfunction

   // --------------------------------------------------
   // shared structs
   // --------------------------------------------------
   // coef8 first so that a [8:0] view indexes by power
   typedef struct packed {
      gf_elem_t coef8;
      gf_elem_t coef7;
      gf_elem_t coef6;
      gf_elem_t coef5;
      gf_elem_t coef4;
      gf_elem_t coef3;
      gf_elem_t coef2;
      gf_elem_t coef1;
      gf_elem_t coef0;
   } lambda_t;

   typedef struct packed {
      logic       active;
      logic [8:0] grp;
      logic       last;
      logic       first;
      logic [3:0] deg;
      logic [7:0] spare;                               // kept at zero
   } scan_stat_t;

   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
   } err_addr_t;

   typedef struct packed {
      logic       done;
      logic [3:0] err_cnt;
      logic       uncorr;
   } dec_result_t;

endpackage

// File: design/chien_scan_ctrl.sv
`timescale 1ns/1ps

module chien_scan_ctrl #(
   parameter int PAR = chien_pkg::PAR_DEFAULT
) (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  start_i,
   input  chien_pkg::lambda_t    lambda_i,
   input  logic                  hold_i,
   output logic                  load_o,
   output logic                  step_o,
   output chien_pkg::lambda_t    lambda_o,
   output chien_pkg::scan_stat_t stat_o,
   output logic                  busy_o
);
   import chien_pkg::*;

   localparam int NGRP = CODE_LEN / PAR;

   lambda_t    lam_q;
   logic       busy_q;
   logic       load_q;
   logic       active_q;
   logic [8:0] grp_q;
   logic [3:0] deg;
   logic       accept;
   logic       last_grp;

   assign accept   = start_i & ~busy_q;
   assign last_grp = (grp_q == 9'(NGRP - 1));

   // degree from highest nonzero coefficient
   always_comb
   begin
      logic [T_MAX:0][GF_M-1:0] c;
      c   = lam_q;
      deg = '0;
      for (int k = 1; k <= T_MAX; k++)
      begin
         if (c[k] != '0)
            deg = 4'(k);
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         lam_q <= lambda_i;
   end

   // --------------------------------------------------
   // scan sequencing
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         busy_q   <= 1'b0;
         load_q   <= 1'b0;
         active_q <= 1'b0;
         grp_q    <= '0;
      end
      else
      begin
         load_q <= accept;                             // cells load next cycle
         if (accept)
            busy_q <= 1'b1;
         if (load_q)
         begin
            active_q <= 1'b1;                          // group 0 in the cells
            grp_q    <= '0;
         end
         else if (step_o)
         begin
            if (last_grp)
            begin
               active_q <= 1'b0;                       // last group released
               busy_q   <= 1'b0;
            end
            else
               grp_q <= grp_q + 9'd1;
         end
      end
   end

   assign step_o   = active_q & ~hold_i;
   assign load_o   = load_q;
   assign lambda_o = lam_q;
   assign busy_o   = busy_q;

   assign stat_o.active = active_q;
   assign stat_o.grp    = grp_q;
   assign stat_o.last   = active_q & last_grp;
   assign stat_o.first  = active_q & (grp_q == '0);
   assign stat_o.deg    = deg;
   assign stat_o.spare  = '0;

   a_no_start_busy: assert property (@(posedge clk) disable iff (!rstn)
      busy_q |-> !start_i);

endmodule

// File: design/chien_top.sv
`timescale 1ns/1ps

module chien_top #(
   parameter int PAR     = chien_pkg::PAR_DEFAULT,
   parameter int CREDITS = 4
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic                   start_i,
   input  chien_pkg::lambda_t     lambda_i,
   input  logic                   credit_i,
   output logic                   busy_o,
   output chien_pkg::err_addr_t   addr_o,
   output chien_pkg::dec_result_t result_o
);
   import chien_pkg::*;

   logic           load;
   logic           step;
   logic           hold;
   lambda_t        lam;
   scan_stat_t     stat;
   logic [PAR-1:0] roots;                             // one bit per lane

   chien_scan_ctrl #(.PAR(PAR)) u_ctrl (
      .clk      (clk),
      .rstn     (rstn),
      .start_i  (start_i),
      .lambda_i (lambda_i),
      .hold_i   (hold),
      .load_o   (load),
      .step_o   (step),
      .lambda_o (lam),
      .stat_o   (stat),
      .busy_o   (busy_o)
   );

   // --------------------------------------------------
   // parallel evaluation lanes
   // --------------------------------------------------
   for (genvar i = 0; i < PAR; i++)
   begin : g_cell
      chien_cell #(.PAR(PAR), .LANE(i)) u_cell (
         .clk      (clk),
         .rstn     (rstn),
         .load_i   (load),
         .step_i   (step),
         .lambda_i (lam),
         .root_o   (roots[i])
      );
   end

   err_addr_collector #(.PAR(PAR), .CREDITS(CREDITS)) u_coll (
      .clk      (clk),
      .rstn     (rstn),
      .root_i   (roots),
      .stat_i   (stat),
      .credit_i (credit_i),
      .hold_o   (hold),
      .addr_o   (addr_o),
      .result_o (result_o)
   );

endmodule

// File: design/err_addr_collector.sv
`timescale 1ns/1ps

module err_addr_collector #(
   parameter int PAR     = chien_pkg::PAR_DEFAULT,
   parameter int CREDITS = 4
) (
   input  logic                   clk,
   input  logic                   rstn,
   input  logic [PAR-1:0]         root_i,
   input  chien_pkg::scan_stat_t  stat_i,
   input  logic                   credit_i,
   output logic                   hold_o,
   output chien_pkg::err_addr_t   addr_o,
   output chien_pkg::dec_result_t result_o
);
   import chien_pkg::*;

   localparam int LW = (PAR > 1) ? $clog2(PAR) : 1;
   localparam int CW = $clog2(CREDITS + 1);

   logic [PAR-1:0] served_q;
   logic [PAR-1:0] pending;
   logic [PAR-1:0] taken;
   logic [LW-1:0]  pick;
   logic           any_pend;
   logic           emit;
   logic           take;
   logic [CW-1:0]  cred_q;
   logic [3:0]     cnt_q;
   logic [3:0]     cnt_base;
   logic [3:0]     cnt_next;
   logic           done_q;
   logic           unc_q;
   logic           scan_end;

   assign pending = stat_i.active ? (root_i & ~served_q) : '0;

   // lowest unserved lane wins
   always_comb
   begin
      pick     = '0;
      any_pend = 1'b0;
      for (int i = PAR - 1; i >= 0; i--)
      begin
         if (pending[i])
         begin
            pick     = LW'(i);
            any_pend = 1'b1;
         end
      end
   end

   // --------------------------------------------------
   // emit / count / hold
   // --------------------------------------------------
   // count restarts on group 0 of a new scan
   assign cnt_base = (stat_i.first && served_q == '0) ? 4'd0 : cnt_q;
   assign emit     = any_pend & (cred_q != '0) & (cnt_base < 4'(T_MAX));
   assign take     = emit | (any_pend & (cnt_base >= 4'(T_MAX)));   // extra roots dropped
   assign cnt_next = (take && cnt_base != 4'hf) ? cnt_base + 4'd1 : cnt_base;
   assign taken    = take ? (PAR'(1) << pick) : '0;
   assign hold_o   = |(pending & ~taken);             // roots left after this cycle
   assign scan_end = stat_i.active & stat_i.last & ~hold_o;

   assign addr_o.valid = emit;
   assign addr_o.addr  = ADDR_W'(int'(stat_i.grp) * PAR + int'(pick));

   always_ff @(posedge clk or negedge rstn)
   begin
      if (!rstn)
      begin
         served_q <= '0;
         cred_q   <= CW'(CREDITS);
         cnt_q    <= '0;
         done_q   <= 1'b0;
         unc_q    <= 1'b0;
      end
      else
      begin
         if (!stat_i.active || !hold_o)
            served_q <= '0;                            // group moves on
         else
            served_q <= served_q | taken;
         cred_q <= cred_q + CW'(credit_i) - CW'(emit);
         cnt_q  <= cnt_next;
         done_q <= scan_end;
         if (scan_end)
            unc_q <= (cnt_next != stat_i.deg) || (cnt_next > 4'(T_MAX));
      end
   end

   assign result_o.done    = done_q;
   assign result_o.err_cnt = cnt_q;
   assign result_o.uncorr  = unc_q;

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   a_credit_max: assert property (@(posedge clk) disable iff (!rstn)
      cred_q <= CW'(CREDITS));

   a_done_no_addr: assert property (@(posedge clk) disable iff (!rstn)
      result_o.done |-> !addr_o.valid);

endmodule

// File: project.f
+incdir+tb
design/chien_pkg.sv
design/chien_scan_ctrl.sv
design/chien_cell.sv
design/err_addr_collector.sv
design/chien_top.sv
tb/chien_tb.sv

// File: tb/chien_tb_util.svh
`ifndef CHIEN_TB_UTIL_SVH
`define CHIEN_TB_UTIL_SVH

typedef int pos_q_t[$];

// one step of a 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(logic [31:0] s);
   logic fb;
   fb = s[31] ^ s[21] ^ s[1] ^ s[0];
   return {s[30:0], fb};
endfunction

// lambda(x) = product of (1 + alpha^p * x) over the error positions
function automatic lambda_t build_locator(pos_q_t pos);
   logic [T_MAX:0][GF_M-1:0] c;
   gf_elem_t                 x;
   c    = '0;
   c[0] = gf_elem_t'(1);
   foreach (pos[j])
   begin
      x = gf_pow_alpha(pos[j]);
      for (int k = T_MAX; k >= 1; k--)
         c[k] = c[k] ^ gf_mul(c[k-1], x);             // multiply by (1 + x*X)
   end
   return lambda_t'(c);
endfunction

// positions inside the scanned range, ascending
function automatic pos_q_t expected_addrs(pos_q_t pos);
   pos_q_t q;
   foreach (pos[j])
   begin
      if (pos[j] < CODE_LEN)
         q.push_back(pos[j]);
   end
   q.sort();
   return q;
endfunction

function automatic bit in_list(pos_q_t pos, int p);
   foreach (pos[j])
   begin
      if (pos[j] == p)
         return 1'b1;
   end
   return 1'b0;
endfunction

`endif

// File: tb/chien_tb.sv
`timescale 1ns/1ps

module chien_tb;
   import chien_pkg::*;

   `include "chien_tb_util.svh"

   localparam int PAR     = 16;
   localparam int CREDITS = 4;

   logic        clk      = 1'b0;
   logic        rstn     = 1'b0;
   logic        start_i  = 1'b0;
   lambda_t     lambda_i = '0;
   logic        credit_i = 1'b0;
   logic        busy_o;
   err_addr_t   addr_o;
   dec_result_t result_o;

   logic [31:0] lfsr = 32'hf1170f5a;
   pos_q_t      exp_q;
   int          exp_cnt;
   bit          exp_unc;
   bit          done_seen;
   int          errors;
   int          n_addr;
   int          n_scan;
   int unsigned cyc;
   int unsigned ret_q[$];                              // edges at which credits go back
   int          outstanding;

   chien_top #(.PAR(PAR), .CREDITS(CREDITS)) uut (
      .clk      (clk),
      .rstn     (rstn),
      .start_i  (start_i),
      .lambda_i (lambda_i),
      .credit_i (credit_i),
      .busy_o   (busy_o),
      .addr_o   (addr_o),
      .result_o (result_o)
   );

   always #10 clk = ~clk;

   function automatic int unsigned draw_bits(int n);
      int unsigned v;
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v    = (v << 1) | lfsr[0];
      end
      return v;
   endfunction

   task automatic fail_value(string msg);
      errors++;
      $display("[FAIL] %0t %s", $time, msg);
   endtask

   task automatic fail_plain(string msg);
      errors++;
      $display("%s", msg);
   endtask

   // --------------------------------------------------
   // consumer returning credits after 0..7 cycles
   // --------------------------------------------------
   always @(posedge clk)
   begin
      int unsigned t;
      logic        give;
      give = 1'b0;
      if (!rstn)
      begin
         cyc         = 0;
         outstanding = 0;
         ret_q.delete();
      end
      else
      begin
         cyc++;
         if (credit_i)
            outstanding--;
         if (addr_o.valid)
         begin
            outstanding++;
            t = cyc + 1 + draw_bits(3);
            if (ret_q.size() != 0 && t <= ret_q[$])
               t = ret_q[$] + 1;                       // one pulse per cycle
            ret_q.push_back(t);
         end
         give = (ret_q.size() != 0 && ret_q[0] == cyc + 1);
         if (give)
            void'(ret_q.pop_front());
      end
      #2;
      credit_i = give;
   end

   // address and summary checks
   always @(posedge clk)
   begin
      if (rstn && addr_o.valid)
      begin
         n_addr++;
         if (exp_q.size() == 0)
            fail_plain($sformatf("address %0d was not expected", addr_o.addr));
         else
         begin
            assert (addr_o.addr == exp_q[0])
               else fail_value($sformatf("address %0d, expected %0d", addr_o.addr, exp_q[0]));
            void'(exp_q.pop_front());
         end
      end
      if (rstn && result_o.done)
      begin
         assert (result_o.err_cnt == 4'(exp_cnt))
            else fail_value($sformatf("count %0d, expected %0d", result_o.err_cnt, exp_cnt));
         assert (result_o.uncorr == exp_unc)
            else fail_value($sformatf("uncorrectable %0b, expected %0b",
                                      result_o.uncorr, exp_unc));
         assert (exp_q.size() == 0)
            else fail_plain($sformatf("%0d addresses never arrived", exp_q.size()));
         n_scan++;
         done_seen = 1'b1;
      end
   end

   a_outstanding: assert property (@(posedge clk) disable iff (!rstn)
      outstanding <= CREDITS)
      else fail_value($sformatf("%0d addresses outstanding", outstanding));

   a_busy_rise: assert property (@(posedge clk) disable iff (!rstn)
      start_i && !busy_o |=> busy_o)
      else fail_plain("busy_o did not rise after start_i was accepted");

   a_done_busy_fall: assert property (@(posedge clk) disable iff (!rstn)
      result_o.done == $fell(busy_o))
      else fail_plain("done and the fall of busy_o are not in the same cycle");

   a_done_pulse: assert property (@(posedge clk) disable iff (!rstn)
      result_o.done |=> !result_o.done)
      else fail_plain("done stayed high for more than one cycle");

   a_addr_busy: assert property (@(posedge clk) disable iff (!rstn)
      addr_o.valid |-> busy_o)
      else fail_plain("an address came out while the decoder was idle");

   // --------------------------------------------------
   // one decode from start to done
   // --------------------------------------------------
   task automatic run_scan(input pos_q_t pos, input string label);
      int n;
      exp_q     = expected_addrs(pos);
      exp_cnt   = exp_q.size();
      exp_unc   = (exp_cnt != pos.size());           // roots vs locator degree
      done_seen = 1'b0;
      $display("scan: %s", label);
      @(posedge clk);
      #2;
      lambda_i = build_locator(pos);
      start_i  = 1'b1;
      @(posedge clk);
      #2;
      start_i = 1'b0;
      for (n = 0; n < 4000 && !done_seen; n++)
         @(posedge clk);
      if (!done_seen)
      begin
         $display("timed out waiting for done in scan %s", label);
         $display("errors: %0d, addresses: %0d, scans: %0d", errors, n_addr, n_scan);
         $display("Test failed");
         $finish;
      end
   endtask

   initial
   begin
      pos_q_t pos;
      int     p;
      repeat (4) @(posedge clk);
      #2;
      rstn = 1'b1;
      @(posedge clk);
      assert (!busy_o && !addr_o.valid && !result_o.done)
         else fail_value("outputs not idle after reset");

      run_scan('{1000}, "single error");
      run_scan('{20, 4223, 17, 18}, "same group");

      pos.delete();
      for (int a = 0; a < 1000 && pos.size() < T_MAX; a++)
      begin
         p = 2000 + int'(draw_bits(5));                // all in groups 125 and 126
         if (!in_list(pos, p))
            pos.push_back(p);
      end
      run_scan(pos, "eight random errors");

      pos.delete();
      run_scan(pos, "no errors");
      run_scan('{5000}, "root out of range");

      repeat (4) @(posedge clk);
      $display("errors: %0d, addresses: %0d, scans: %0d", errors, n_addr, n_scan);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule
